// ==== spin_readout_consts.svh ====
`ifndef SPIN_READOUT_CONSTS_SVH
`define SPIN_READOUT_CONSTS_SVH

// Width of one spin vector from the annealer macro
`define SPIN_DATAW 64

// Deepest synchronizer tap that pipe_num may select
`define SYNC_PIPEDEPTH 3

// Entries in the transmit FIFO
`define TXBUF_DEPTH 4

// Credits granted by the downstream side out of reset
`define TX_CREDITS 2

// Set to 1 to place the AND isolation gating in front of the
// synchronizer, 0 to feed the macro outputs straight in
`define SYNC_ISOLATION 1

`endif

// ==== spin_readout_pkg.sv ====
package spin_readout_pkg;

    // Command opcode, always in the top two bits of the word
    typedef enum logic [1:0] {
        NOP   = 2'd0,
        CFG   = 2'd1,
        RUN   = 2'd2,
        ABORT = 2'd3
    } cmd_opcode_e;

    // Configuration view of a command word
    typedef struct packed {
        cmd_opcode_e opcode;
        logic [1:0]  pipe_num;
        logic [11:0] anneal_cycles;
    } cfg_cmd_t;

    // Run view of a command word
    typedef struct packed {
        cmd_opcode_e opcode;
        logic [5:0]  sample_count;
        logic [7:0]  sample_interval;
    } run_cmd_t;

    // One 16-bit command, read through whichever view the opcode selects
    typedef union packed {
        cfg_cmd_t cfg;
        run_cmd_t run;
    } cmd_word_u;

    // Readout controller states
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        ANNEAL = 3'd1,
        WAIT   = 3'd2,
        SAMPLE = 3'd3,
        DRAIN  = 3'd4
    } readout_state_e;

endpackage

// ==== settle_timer_if.sv ====
`timescale 1ns/1ps

interface settle_timer_if;

    // Start pulse and the cycle count it loads
    logic        load;
    logic [11:0] load_value;

    // Timer status back to the controller
    logic        busy;
    logic        expired;

    modport ctrl (
        output load,
        output load_value,
        input  busy,
        input  expired
    );

    modport timer (
        input  load,
        input  load_value,
        output busy,
        output expired
    );

endinterface

// ==== synchronizer.sv ====
`timescale 1ns/1ps

`include "spin_readout_consts.svh"

module synchronizer #(
    parameter int DATAW     = `SPIN_DATAW,
    parameter int PIPEDEPTH = `SYNC_PIPEDEPTH
) (
    input  logic                               clk_i,
    input  logic                               reset_i,
    input  logic                               en_i,
    input  logic [DATAW-1:0]                   data_in_i,
    input  logic [$clog2(PIPEDEPTH+1)-1:0]     pipe_num_i,
    input  logic                               synchronization_en_i,
    output logic                               data_out_valid_o,
    output logic [DATAW-1:0]                   data_out_o
);

    logic [DATAW-1:0]                gated_data;
    logic [PIPEDEPTH:0][DATAW-1:0]   data_stage;
    logic [PIPEDEPTH:0]              valid_stage;
    logic [PIPEDEPTH-1:0]            shift_cond;

    // Isolation gating keeps the macro outputs at zero outside the sample window
    generate
        if (`SYNC_ISOLATION == 1) begin : gen_isolation
            assign gated_data = data_in_i & {DATAW{synchronization_en_i}};
        end else begin : gen_no_isolation
            assign gated_data = data_in_i;
        end
    endgenerate

    // Stage 0 is the gated macro output itself
    assign valid_stage[0] = synchronization_en_i;
    assign data_stage[0]  = gated_data;

    generate
        for (genvar i = 0; i < PIPEDEPTH; i++) begin : gen_stage
            assign shift_cond[i] = en_i & valid_stage[i];

            // Dropping en_i flushes every word still in flight
            always_ff @(posedge clk_i) begin
                if (reset_i || !en_i) begin
                    valid_stage[i+1] <= 1'b0;
                end else begin
                    valid_stage[i+1] <= valid_stage[i];
                end
            end

            // Payload only moves when a valid word sits in the stage before
            always_ff @(posedge clk_i) begin
                if (shift_cond[i]) begin
                    data_stage[i+1] <= data_stage[i];
                end
            end
        end
    endgenerate

    // Tap select, out of range settings use the unregistered path
    always_comb begin
        if (pipe_num_i <= PIPEDEPTH) begin
            data_out_valid_o = valid_stage[pipe_num_i];
            data_out_o       = data_stage[pipe_num_i];
        end else begin
            data_out_valid_o = valid_stage[0];
            data_out_o       = data_stage[0];
        end
    end

endmodule

// ==== settle_timer.sv ====
`timescale 1ns/1ps

module settle_timer (
    input  logic          clk_i,
    input  logic          reset_i,
    settle_timer_if.timer tmr
);

    logic [11:0] count_q;
    logic        run_q;

    // A load of N makes expired fire N cycles later; zero behaves like one
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count_q <= '0;
            run_q   <= 1'b0;
        end else if (tmr.load) begin
            if (tmr.load_value == '0) begin
                count_q <= '0;
            end else begin
                count_q <= tmr.load_value - 12'd1;
            end
            run_q <= 1'b1;
        end else if (run_q) begin
            if (count_q == '0) begin
                run_q <= 1'b0;
            end else begin
                count_q <= count_q - 12'd1;
            end
        end
    end

    assign tmr.busy = run_q;

    // Single-cycle pulse on the last counting cycle
    assign tmr.expired = run_q && (count_q == '0);

endmodule

// ==== readout_fsm.sv ====
`timescale 1ns/1ps

module readout_fsm (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        cmd_valid_i,
    input  spin_readout_pkg::cmd_word_u cmd_i,
    input  logic                        slot_avail_i,
    settle_timer_if.ctrl                tmr,
    output logic                        anneal_o,
    output logic                        sample_en_o,
    output logic                        pipe_run_o,
    output logic [1:0]                  pipe_num_o,
    output logic                        busy_o
);

    spin_readout_pkg::readout_state_e state_q;
    spin_readout_pkg::cmd_opcode_e    opcode;

    logic        cmd_abort;
    logic        cmd_run;
    logic [1:0]  pipe_num_q;
    logic [11:0] anneal_cycles_q;
    logic [7:0]  interval_q;
    logic [5:0]  samples_left_q;

    // The opcode sits in the same bits of both views
    assign opcode    = cmd_i.cfg.opcode;
    assign cmd_abort = cmd_valid_i && (opcode == spin_readout_pkg::ABORT);
    assign cmd_run   = cmd_valid_i && (opcode == spin_readout_pkg::RUN);

    // Timer loads and the sample strobe
    always_comb begin
        tmr.load       = 1'b0;
        tmr.load_value = '0;
        sample_en_o    = 1'b0;
        case (state_q)
            spin_readout_pkg::IDLE: begin
                if (cmd_run) begin
                    tmr.load       = 1'b1;
                    tmr.load_value = anneal_cycles_q;
                end
            end
            spin_readout_pkg::ANNEAL: begin
                if (tmr.expired && samples_left_q != '0) begin
                    tmr.load       = 1'b1;
                    tmr.load_value = {4'd0, interval_q};
                end
            end
            spin_readout_pkg::SAMPLE: begin
                if (slot_avail_i) begin
                    sample_en_o = 1'b1;
                    if (samples_left_q != 6'd1) begin
                        tmr.load       = 1'b1;
                        tmr.load_value = {4'd0, interval_q};
                    end else if (pipe_num_q != '0) begin
                        // Last sample, time the pipe drain
                        tmr.load       = 1'b1;
                        tmr.load_value = {10'd0, pipe_num_q};
                    end
                end
            end
            default: begin
            end
        endcase
        if (cmd_abort) begin
            tmr.load    = 1'b0;
            sample_en_o = 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q         <= spin_readout_pkg::IDLE;
            pipe_num_q      <= '0;
            anneal_cycles_q <= '0;
            interval_q      <= '0;
            samples_left_q  <= '0;
        end else if (cmd_abort) begin
            state_q <= spin_readout_pkg::IDLE;
        end else begin
            case (state_q)
                spin_readout_pkg::IDLE: begin
                    if (cmd_valid_i && opcode == spin_readout_pkg::CFG) begin
                        pipe_num_q      <= cmd_i.cfg.pipe_num;
                        anneal_cycles_q <= cmd_i.cfg.anneal_cycles;
                    end else if (cmd_run) begin
                        samples_left_q <= cmd_i.run.sample_count;
                        interval_q     <= cmd_i.run.sample_interval;
                        state_q        <= spin_readout_pkg::ANNEAL;
                    end
                end
                spin_readout_pkg::ANNEAL: begin
                    if (tmr.expired) begin
                        state_q <= (samples_left_q == '0) ? spin_readout_pkg::DRAIN
                                                          : spin_readout_pkg::WAIT;
                    end
                end
                spin_readout_pkg::WAIT: begin
                    if (tmr.expired) begin
                        state_q <= spin_readout_pkg::SAMPLE;
                    end
                end
                spin_readout_pkg::SAMPLE: begin
                    // Hold here while the buffer has no free slot
                    if (slot_avail_i) begin
                        samples_left_q <= samples_left_q - 6'd1;
                        state_q <= (samples_left_q == 6'd1) ? spin_readout_pkg::DRAIN
                                                            : spin_readout_pkg::WAIT;
                    end
                end
                spin_readout_pkg::DRAIN: begin
                    // No timer running means nothing is left in the pipe
                    if (tmr.expired || !tmr.busy) begin
                        state_q <= spin_readout_pkg::IDLE;
                    end
                end
                default: begin
                    state_q <= spin_readout_pkg::IDLE;
                end
            endcase
        end
    end

    assign anneal_o   = (state_q == spin_readout_pkg::ANNEAL);
    assign busy_o     = (state_q != spin_readout_pkg::IDLE);
    assign pipe_run_o = busy_o && !cmd_abort;
    assign pipe_num_o = pipe_num_q;

endmodule

// ==== spin_tx_buffer.sv ====
`timescale 1ns/1ps

`include "spin_readout_consts.svh"

module spin_tx_buffer #(
    parameter int DEPTH   = `TXBUF_DEPTH,
    parameter int CREDITS = `TX_CREDITS
) (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   reserve_i,
    input  logic                   wr_valid_i,
    input  logic [`SPIN_DATAW-1:0] wr_data_i,
    input  logic                   credit_return_i,
    output logic                   slot_avail_o,
    output logic                   tx_valid_o,
    output logic [`SPIN_DATAW-1:0] tx_data_o
);

    localparam int PTRW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNTW = $clog2(DEPTH + 1);
    localparam int CRW  = $clog2(CREDITS + 1);
    localparam int QW   = $clog2(`SYNC_PIPEDEPTH + 1);

    logic [`SPIN_DATAW-1:0] mem [DEPTH];
    logic [PTRW-1:0]        wr_ptr_q;
    logic [PTRW-1:0]        rd_ptr_q;
    logic [CNTW-1:0]        count_q;
    logic [CNTW-1:0]        reserved_q;
    logic [CRW-1:0]         credits_q;
    logic [QW-1:0]          quiet_q;
    logic [CNTW:0]          committed;
    logic                   send;

    // A slot is free when stored words plus words still in the pipe leave room
    assign committed    = {1'b0, count_q} + {1'b0, reserved_q};
    assign slot_avail_o = (committed < DEPTH);

    assign send       = (credits_q != '0) && (count_q != '0);
    assign tx_valid_o = send;
    assign tx_data_o  = mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (wr_valid_i) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            reserved_q <= '0;
            credits_q  <= CRW'(CREDITS);
            quiet_q    <= '0;
        end else begin
            if (wr_valid_i) begin
                wr_ptr_q <= (wr_ptr_q == PTRW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (send) begin
                rd_ptr_q <= (rd_ptr_q == PTRW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({wr_valid_i, send})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            case ({credit_return_i, send})
                2'b10:   credits_q <= credits_q + 1'b1;
                2'b01:   credits_q <= credits_q - 1'b1;
                default: credits_q <= credits_q;
            endcase
            // Reservations left over from an aborted pipe expire once the
            // deepest tap has had time to deliver
            if (reserve_i) begin
                quiet_q <= '0;
            end else if (quiet_q != QW'(`SYNC_PIPEDEPTH)) begin
                quiet_q <= quiet_q + 1'b1;
            end
            if (quiet_q == QW'(`SYNC_PIPEDEPTH) && !reserve_i) begin
                reserved_q <= '0;
            end else begin
                case ({reserve_i, wr_valid_i})
                    2'b10:   reserved_q <= reserved_q + 1'b1;
                    2'b01:   reserved_q <= reserved_q - 1'b1;
                    default: reserved_q <= reserved_q;
                endcase
            end
        end
    end

endmodule

// ==== spin_readout_top.sv ====
`timescale 1ns/1ps

`include "spin_readout_consts.svh"

module spin_readout_top (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   cmd_valid_i,
    input  logic [15:0]            cmd_i,
    input  logic [`SPIN_DATAW-1:0] spin_data_i,
    input  logic                   credit_return_i,
    output logic                   anneal_o,
    output logic                   sample_o,
    output logic                   busy_o,
    output logic                   tx_valid_o,
    output logic [`SPIN_DATAW-1:0] tx_data_o
);

    spin_readout_pkg::cmd_word_u cmd_word;

    logic                   sample_en;
    logic                   pipe_run;
    logic [1:0]             pipe_num;
    logic                   slot_avail;
    logic                   sync_valid;
    logic [`SPIN_DATAW-1:0] sync_data;

    settle_timer_if tmr_if ();

    assign cmd_word = cmd_i;

    // The sample strobe doubles as the macro enable and the slot reservation
    assign sample_o = sample_en;

    readout_fsm readout_fsm_inst (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_i        (cmd_word),
        .slot_avail_i (slot_avail),
        .tmr          (tmr_if.ctrl),
        .anneal_o     (anneal_o),
        .sample_en_o  (sample_en),
        .pipe_run_o   (pipe_run),
        .pipe_num_o   (pipe_num),
        .busy_o       (busy_o)
    );

    settle_timer settle_timer_inst (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .tmr     (tmr_if.timer)
    );

    synchronizer #(
        .DATAW     (`SPIN_DATAW),
        .PIPEDEPTH (`SYNC_PIPEDEPTH)
    ) synchronizer_inst (
        .clk_i                (clk_i),
        .reset_i              (reset_i),
        .en_i                 (pipe_run),
        .data_in_i            (spin_data_i),
        .pipe_num_i           (pipe_num),
        .synchronization_en_i (sample_en),
        .data_out_valid_o     (sync_valid),
        .data_out_o           (sync_data)
    );

    spin_tx_buffer #(
        .DEPTH   (`TXBUF_DEPTH),
        .CREDITS (`TX_CREDITS)
    ) spin_tx_buffer_inst (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .reserve_i       (sample_en),
        .wr_valid_i      (sync_valid),
        .wr_data_i       (sync_data),
        .credit_return_i (credit_return_i),
        .slot_avail_o    (slot_avail),
        .tx_valid_o      (tx_valid_o),
        .tx_data_o       (tx_data_o)
    );

endmodule

// ==== spin_readout_sva.sv ====
`timescale 1ns/1ps

`include "spin_readout_consts.svh"

module spin_readout_sva (
    input logic clk_i,
    input logic reset_i,
    input logic anneal_i,
    input logic sample_i,
    input logic busy_i,
    input logic tx_valid_i,
    input logic credit_return_i
);

    logic [7:0] credits_q;

    // Link-side credit count of grants plus returns minus sends
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            credits_q <= 8'(`TX_CREDITS);
        end else begin
            credits_q <= credits_q + 8'(credit_return_i) - 8'(tx_valid_i);
        end
    end

    // Downstream link only sends against a credit
    tx_needs_credit: assert property (
        @(posedge clk_i) disable iff (reset_i)
        tx_valid_i |-> credits_q != '0
    ) else $error("tx_valid_o raised with no credit left");

    // Samples come only during a run and never in two cycles in a row
    sample_spacing: assert property (
        @(posedge clk_i) disable iff (reset_i)
        sample_i |-> busy_i ##1 !sample_i
    ) else $error("sample_o raised outside a run or in back-to-back cycles");

    // Anneal and sampling never overlap
    anneal_excludes_sample: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !(anneal_i && sample_i)
    ) else $error("anneal_o and sample_o high together");

    // Control outputs quiet right after reset
    quiet_after_reset: assert property (
        @(posedge clk_i)
        reset_i |=> !tx_valid_i && !anneal_i && !sample_i && !busy_i
    ) else $error("control output high after reset");

endmodule

// ==== tb_spin_readout.sv ====
`timescale 1ns/1ps

`include "spin_readout_consts.svh"

module tb_spin_readout;

    // One table row of commands, credit hold time, intrusion, abort point and word count
    typedef struct packed {
        spin_readout_pkg::cfg_cmd_t cfg;
        spin_readout_pkg::run_cmd_t run;
        int                         hold;
        bit                         intrude;
        int                         abort_after;
        int                         exp_words;
    } test_t;

    localparam int NUM_TESTS = 5;

    logic                   clk;
    logic                   reset;
    logic                   cmd_valid;
    logic [15:0]            cmd;
    logic [`SPIN_DATAW-1:0] spin_data;
    logic                   credit_return;
    logic                   anneal;
    logic                   sample;
    logic                   busy;
    logic                   tx_valid;
    logic [`SPIN_DATAW-1:0] tx_data;

    test_t                  tests [NUM_TESTS];
    logic [`SPIN_DATAW-1:0] exp_q [$];
    integer                 seed;
    int                     cycle_cnt;
    int                     limit_cycles;
    int                     err_cnt;
    int                     check_cnt;
    int                     anneal_total;
    int                     sample_total;
    int                     rx_total;
    int                     returned_total;
    int                     last_sample_cycle;
    int                     busy_fall_cycle;
    logic                   busy_prev;
    bit                     withhold;

    spin_readout_top spin_readout_top_inst (
        .clk_i           (clk),
        .reset_i         (reset),
        .cmd_valid_i     (cmd_valid),
        .cmd_i           (cmd),
        .spin_data_i     (spin_data),
        .credit_return_i (credit_return),
        .anneal_o        (anneal),
        .sample_o        (sample),
        .busy_o          (busy),
        .tx_valid_o      (tx_valid),
        .tx_data_o       (tx_data)
    );

    bind spin_readout_top spin_readout_sva spin_readout_sva_inst (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .anneal_i        (anneal_o),
        .sample_i        (sample_o),
        .busy_i          (busy_o),
        .tx_valid_i      (tx_valid_o),
        .credit_return_i (credit_return_i)
    );

    function automatic test_t make_test(input int pipe, input int anneal_len, input int count,
                                        input int interval, input int hold, input bit intrude,
                                        input int abort_after, input int exp_words);
        test_t t;
        t.cfg.opcode          = spin_readout_pkg::CFG;
        t.cfg.pipe_num        = 2'(pipe);
        t.cfg.anneal_cycles   = 12'(anneal_len);
        t.run.opcode          = spin_readout_pkg::RUN;
        t.run.sample_count    = 6'(count);
        t.run.sample_interval = 8'(interval);
        t.hold                = hold;
        t.intrude             = intrude;
        t.abort_after         = abort_after;
        t.exp_words           = exp_words;
        return t;
    endfunction

    task automatic check_word(input logic [`SPIN_DATAW-1:0] got,
                              input logic [`SPIN_DATAW-1:0] exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        check_cnt++;
        if (got != exp) begin
            err_cnt++;
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic send_cmd(input spin_readout_pkg::cmd_word_u word);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd       <= word;
        @(posedge clk);
        cmd_valid <= 1'b0;
        cmd       <= '0;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (limit_cycles > 0 && cycle_cnt > limit_cycles) begin
            $display("Timeout: tests still running after %0d cycles", cycle_cnt);
            $display("Errors found");
            $finish;
        end
    end

    // Analog macro model and the downstream credit return
    always @(posedge clk) begin
        spin_data <= {$random(seed), $random(seed)};
        if (reset) begin
            credit_return <= 1'b0;
        end else if (rx_total != returned_total && !withhold) begin
            credit_return  <= 1'b1;
            returned_total = returned_total + 1;
        end else begin
            credit_return <= 1'b0;
        end
    end

    // Scoreboard samples mid-cycle where everything is settled
    always @(negedge clk) begin
        if (!reset) begin
            if (anneal) begin
                anneal_total++;
            end
            if (sample) begin
                exp_q.push_back(spin_data);
                sample_total++;
                last_sample_cycle = cycle_cnt;
            end
            if (busy_prev && !busy) begin
                busy_fall_cycle = cycle_cnt;
            end
            busy_prev = busy;
            if (tx_valid) begin
                rx_total++;
                if (exp_q.size() == 0) begin
                    err_cnt++;
                    $display("Word sent on the tx link at %0t with no sample pending", $time);
                end else begin
                    check_word(tx_data, exp_q.pop_front(), "tx word");
                end
            end
        end
    end

    task automatic run_test(input int idx);
        test_t                       t;
        spin_readout_pkg::cmd_word_u word;
        int                          a0;
        int                          s0;
        int                          r0;
        int                          errs0;
        int                          pipe;
        int                          drain;
        t = tests[idx];
        pipe = t.cfg.pipe_num;
        @(negedge clk);
        a0       = anneal_total;
        s0       = sample_total;
        r0       = rx_total;
        errs0    = err_cnt;
        withhold = (t.hold != 0);
        word.cfg = t.cfg;
        send_cmd(word);
        word.run = t.run;
        send_cmd(word);
        if (t.intrude) begin
            @(negedge clk);
            check_bit(busy, 1'b1, "busy during anneal");
            word.cfg               = t.cfg;
            word.cfg.pipe_num      = 2'd0;
            word.cfg.anneal_cycles = 12'd40;
            send_cmd(word);
            word.run              = t.run;
            word.run.sample_count = 6'd1;
            send_cmd(word);
        end
        if (t.hold != 0) begin
            repeat (t.hold) @(negedge clk);
            check_count(rx_total - r0, `TX_CREDITS, "words sent without credit returns");
            check_count(sample_total - s0, `TX_CREDITS + `TXBUF_DEPTH,
                        "samples before back-pressure pause");
            withhold = 1'b0;
        end
        if (t.abort_after != 0) begin
            while (sample_total - s0 < t.abort_after) @(posedge clk);
            word            = '0;
            word.cfg.opcode = spin_readout_pkg::ABORT;
            send_cmd(word);
            @(negedge clk);
            check_bit(busy, 1'b0, "busy after abort");
            check_bit(sample, 1'b0, "sample after abort");
            // Words already in the FIFO still go out
            repeat (16) @(negedge clk);
            check_count(sample_total - s0, t.abort_after, "samples before abort");
            check_count(rx_total - r0, t.exp_words, "words delivered before abort");
            exp_q.delete();
        end else begin
            @(negedge clk);
            while (busy) @(negedge clk);
            @(posedge clk);
            while (rx_total - r0 < t.exp_words) @(posedge clk);
            drain = busy_fall_cycle - last_sample_cycle - 1;
            check_count(sample_total - s0, t.run.sample_count, "sample pulses");
            check_bit(drain >= pipe && drain <= pipe + 1, 1'b1, "drain covers the pipe depth");
            check_count(exp_q.size(), 0, "samples never delivered");
        end
        check_count(anneal_total - a0, t.cfg.anneal_cycles, "anneal length");
        while (rx_total != returned_total) @(negedge clk);
        $display("Test %0d: pipe %0d, %0d samples, %0d words, %s", idx, pipe,
                 sample_total - s0, rx_total - r0, (err_cnt == errs0) ? "ok" : "FAILED");
    endtask

    initial begin
        int k;
        seed          = 32'h9de4;
        reset         <= 1'b1;
        cmd_valid     <= 1'b0;
        cmd           <= '0;
        spin_data     <= '0;
        credit_return <= 1'b0;
        busy_prev     = 1'b0;
        withhold      = 1'b0;
        tests[0] = make_test(0, 5, 4, 3, 0, 1'b0, 0, 4);
        tests[1] = make_test(1, 12, 5, 1, 0, 1'b0, 0, 5);
        tests[2] = make_test(2, 7, 9, 2, 150, 1'b0, 0, 9);
        tests[3] = make_test(3, 9, 5, 4, 0, 1'b1, 0, 5);
        tests[4] = make_test(3, 6, 8, 6, 0, 1'b0, 3, 2);
        limit_cycles = 400;
        for (k = 0; k < NUM_TESTS; k++) begin
            limit_cycles += tests[k].cfg.anneal_cycles + tests[k].hold
                          + tests[k].run.sample_count * (tests[k].run.sample_interval + 8);
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_bit(busy, 1'b0, "busy after reset");
        check_bit(anneal, 1'b0, "anneal after reset");
        check_bit(tx_valid, 1'b0, "tx_valid after reset");
        for (k = 0; k < NUM_TESTS; k++) begin
            run_test(k);
        end
        $display("Tests: %0d, checks: %0d, errors: %0d", NUM_TESTS, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+.
spin_readout_pkg.sv
settle_timer_if.sv
synchronizer.sv
settle_timer.sv
readout_fsm.sv
spin_tx_buffer.sv
spin_readout_top.sv
spin_readout_sva.sv
tb_spin_readout.sv
